// File: hw/fetch_pkg.sv
package fetch_pkg;

    // requester address and returned byte
    localparam int ADDR_W = 4;
    localparam int DATA_W = 8;

    // one line per address, so nothing is ever evicted
    localparam int DEPTH = 1 << ADDR_W;

    // idle waits for req
    // lookup checks the line
    // fill returns the ROM byte after a miss
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_lookup = 2'd1,
        st_fill   = 2'd2
    } fetch_state_t;

endpackage

// File: hw/cache_if.sv
`timescale 1ns/1ps

interface cache_if;

    // driven by the fetch controller
    logic                          cs;
    logic                          we;
    logic [fetch_pkg::ADDR_W-1:0]  addr;
    logic [fetch_pkg::DATA_W-1:0]  wdata;

    // driven by the line store, follows addr
    logic [fetch_pkg::DATA_W-1:0]  rdata;
    logic                          line_valid;

    modport ctrl (
        output cs, we, addr, wdata,
        input  rdata, line_valid
    );

    modport store (
        input  cs, we, addr, wdata,
        output rdata, line_valid
    );

endinterface

// File: hw/backing_rom.sv
`timescale 1ns/1ps

module backing_rom (
    input  logic [fetch_pkg::ADDR_W-1:0] rom_addr,
    output logic [fetch_pkg::DATA_W-1:0] rom_data
);

    logic [fetch_pkg::DATA_W-1:0] rom_mem [fetch_pkg::DEPTH];

    // contents come from the image file in the run directory
    initial begin
        $readmemh("rom_image.hex", rom_mem);
    end

    // asynchronous read, the cache samples it during lookup and fill
    always_comb begin
        rom_data = rom_mem[rom_addr];
    end

endmodule

// File: hw/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic    clk,
    input  logic    rst,
    cache_if.store  bus
);

    logic [fetch_pkg::DATA_W-1:0] line_mem [fetch_pkg::DEPTH];
    logic [fetch_pkg::DEPTH-1:0]  valid_bits;
    logic                         wr_en;

    assign wr_en = bus.cs && bus.we;

    // data array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[bus.addr] <= bus.wdata;
        end
    end

    // valid bits, cleared by reset and set by a fill
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[bus.addr] <= 1'b1;
        end
    end

    // combinational read follows addr
    always_comb begin
        bus.rdata      = line_mem[bus.addr];
        bus.line_valid = valid_bits[bus.addr];
    end

    // reset leaves every line empty
    a_reset_invalidates: assert property (
        @(posedge clk) rst |=> (valid_bits == '0)
    ) else $error("line_store: line still valid after reset");

    // the controller only fills lines that missed
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !valid_bits[bus.addr]
    ) else $error("line_store: fill of a line that is already valid");

endmodule

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic [fetch_pkg::ADDR_W-1:0]  addr,
    output logic [fetch_pkg::ADDR_W-1:0]  rom_addr,
    input  logic [fetch_pkg::DATA_W-1:0]  rom_data,
    cache_if.ctrl                         bus,
    output logic [fetch_pkg::DATA_W-1:0]  data,
    output logic                          valid,
    output logic                          hit
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    logic [fetch_pkg::ADDR_W-1:0] addr_q;
    logic                         accept;
    logic                         lookup_hit;
    logic                         lookup_miss;

    // req only counts while idle
    assign accept      = (state == fetch_pkg::st_idle) && req;
    assign lookup_hit  = (state == fetch_pkg::st_lookup) && bus.line_valid;
    assign lookup_miss = (state == fetch_pkg::st_lookup) && !bus.line_valid;

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::st_idle: begin
                if (req) begin
                    state_next = fetch_pkg::st_lookup;
                end
            end
            fetch_pkg::st_lookup: begin
                if (bus.line_valid) begin
                    state_next = fetch_pkg::st_idle;
                end else begin
                    state_next = fetch_pkg::st_fill;
                end
            end
            fetch_pkg::st_fill: begin
                state_next = fetch_pkg::st_idle;
            end
            default: begin
                state_next = fetch_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // accepted address, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
        end
    end

    // same address goes to the ROM and the store
    assign rom_addr  = addr_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = rom_data;

    // fill write lands on the lookup edge
    assign bus.cs = (state == fetch_pkg::st_lookup);
    assign bus.we = lookup_miss;

    // returned byte and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            hit   <= 1'b0;
            data  <= '0;
        end else begin
            valid <= 1'b0;
            if (lookup_hit) begin
                valid <= 1'b1;
                hit   <= 1'b1;
                data  <= bus.rdata;
            end else if (state == fetch_pkg::st_fill) begin
                valid <= 1'b1;
                hit   <= 1'b0;
                data  <= rom_data;
            end
        end
    end

    // one pulse per request, no back-to-back valid
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (rst)
        valid |=> !valid
    ) else $error("fetch_ctrl: valid held longer than one cycle");

    // fill write only right after an accept, for a line the store reports empty
    a_we_on_miss: assert property (
        @(posedge clk) disable iff (rst)
        bus.we |-> $past(accept) && !bus.line_valid
    ) else $error("fetch_ctrl: write outside a lookup miss");

    // a miss is answered from the ROM one edge later
    a_miss_returns: assert property (
        @(posedge clk) disable iff (rst)
        lookup_miss |=> ##1 (valid && !hit)
    ) else $error("fetch_ctrl: miss not returned after fill");

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic [fetch_pkg::ADDR_W-1:0]  addr,
    output logic [fetch_pkg::DATA_W-1:0]  data,
    output logic                          valid,
    output logic                          hit
);

    logic [fetch_pkg::ADDR_W-1:0] rom_addr;
    logic [fetch_pkg::DATA_W-1:0] rom_data;

    // controller to line store
    cache_if i_cache_if ();

    backing_rom i_rom (
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    line_store i_store (
        .clk (clk),
        .rst (rst),
        .bus (i_cache_if.store)
    );

    fetch_ctrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .addr     (addr),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .bus      (i_cache_if.ctrl),
        .data     (data),
        .valid    (valid),
        .hit      (hit)
    );

endmodule

// File: dv/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int QUIET_CYCLES   = 6;

    logic                         clk;
    logic                         rst;
    logic                         req;
    logic [fetch_pkg::ADDR_W-1:0] addr;
    logic [fetch_pkg::DATA_W-1:0] data;
    logic                         valid;
    logic                         hit;

    int tests;
    int failed_tests;
    int errors;
    bit aborted;

    fetch_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .addr  (addr),
        .data  (data),
        .valid (valid),
        .hit   (hit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // rst high for five rising edges, released on a falling edge
    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        req = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_reset_state();
        if (valid !== 1'b0) begin
            $display("FAIL reset: valid got 0x%h expected 0x0", valid);
            errors++;
        end
        if (hit !== 1'b0) begin
            $display("FAIL reset: hit got 0x%h expected 0x0", hit);
            errors++;
        end
        if (data !== '0) begin
            $display("FAIL reset: data got 0x%h expected 0x00", data);
            errors++;
        end
    endtask

    // one request, optionally with a second req to another address while busy
    task automatic run_read(
        input logic [fetch_pkg::ADDR_W-1:0] a,
        input logic [fetch_pkg::DATA_W-1:0] exp_data,
        input logic                         exp_hit,
        input bit                           busy
    );
        int edges;
        int waited;
        int exp_latency;
        bit seen;
        edges = 0;
        waited = 0;
        seen = 1'b0;
        // hit answers on the second edge after acceptance, miss one later
        exp_latency = exp_hit ? 2 : 3;
        @(negedge clk);
        req  = 1'b1;
        addr = a;
        // accepting edge
        @(posedge clk);
        @(negedge clk);
        if (busy) begin
            req  = 1'b1;
            addr = a ^ 4'hf;
        end else begin
            req = 1'b0;
        end
        // a busy req stays up until the answer arrives
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            edges++;
            waited++;
            @(negedge clk);
            if (valid) begin
                seen = 1'b1;
            end
        end
        req = 1'b0;
        if (!seen) begin
            $display("timeout waiting for valid after a read of address 0x%h", a);
            errors++;
            aborted = 1'b1;
        end else begin
            if (data !== exp_data) begin
                $display("FAIL addr 0x%h: data got 0x%h expected 0x%h", a, data, exp_data);
                errors++;
            end
            if (hit !== exp_hit) begin
                $display("FAIL addr 0x%h: hit got 0x%h expected 0x%h", a, hit, exp_hit);
                errors++;
            end
            if (edges + 1 != exp_latency) begin
                $display("FAIL addr 0x%h: latency got 0x%h expected 0x%h",
                         a, edges + 1, exp_latency);
                errors++;
            end
            // single pulse, outputs held afterwards
            repeat (QUIET_CYCLES) begin
                @(posedge clk);
                @(negedge clk);
                if (valid !== 1'b0) begin
                    $display("FAIL addr 0x%h: valid got 0x%h expected 0x0 after the pulse",
                             a, valid);
                    errors++;
                end
                if (data !== exp_data) begin
                    $display("FAIL addr 0x%h: data got 0x%h expected 0x%h while held",
                             a, data, exp_data);
                    errors++;
                end
                if (hit !== exp_hit) begin
                    $display("FAIL addr 0x%h: hit got 0x%h expected 0x%h while held",
                             a, hit, exp_hit);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int fd;
        int n;
        int a;
        int d;
        int h;
        int errors_before;
        string line;
        string op;
        rst = 1'b1;
        req = 1'b0;
        addr = '0;
        tests = 0;
        failed_tests = 0;
        errors = 0;
        aborted = 1'b0;
        line = "";
        op = "";

        apply_reset();
        check_reset_state();
        tests++;
        if (errors != 0) begin
            failed_tests++;
            $display("test %0d reset state: failed", tests);
        end else begin
            $display("test %0d reset state: ok", tests);
        end

        fd = $fopen("dv/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/fetch_patterns.txt");
            errors++;
        end else begin
            while (!aborted && !$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h", op, a, d, h);
                    if (n == 4) begin
                        errors_before = errors;
                        tests++;
                        if (op == "read") begin
                            run_read(a[fetch_pkg::ADDR_W-1:0], d[fetch_pkg::DATA_W-1:0],
                                     h[0], 1'b0);
                        end else if (op == "busy") begin
                            run_read(a[fetch_pkg::ADDR_W-1:0], d[fetch_pkg::DATA_W-1:0],
                                     h[0], 1'b1);
                        end else if (op == "reset") begin
                            apply_reset();
                            check_reset_state();
                        end else begin
                            $display("unknown operation %s in the pattern file", op);
                            errors++;
                        end
                        if (errors != errors_before) begin
                            failed_tests++;
                            $display("test %0d %s addr 0x%h: failed", tests, op, a);
                        end else begin
                            $display("test %0d %s addr 0x%h: ok", tests, op, a);
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d",
                 tests, tests - failed_tests, failed_tests);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
hw/fetch_pkg.sv
hw/cache_if.sv
hw/backing_rom.sv
hw/line_store.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
dv/tb_fetch.sv

// File: run.sh
#!/bin/sh
# build and run the fetch cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch -f project.f -o tb_fetch_sim

# the ROM image and the pattern file are read relative to the project root
output=$(./obj_dir/tb_fetch_sim)
echo "$output"
echo "$output" | grep -qx "Regression passed"

// File: rom_image.hex
// one byte per ROM address, address 0 first
3c
a7
19
e2
5b
80
f4
06
d1
6e
2f
98
c5
43
7a
bd

// File: dv/fetch_patterns.txt
# op     addr  byte  hit   (addr, byte and hit in hex, byte copies rom_image.hex)
# read = one request, busy = extra req to addr^f while busy, reset = pulse rst
read     0     3c    0
read     0     3c    1
read     1     a7    0
read     2     19    0
read     1     a7    1
read     4     5b    0
read     5     80    0
read     6     f4    0
read     7     06    0
read     5     80    1
read     8     d1    0
busy     3     e2    0
read     c     c5    0
read     3     e2    1
busy     3     e2    1
read     9     6e    0
read     a     2f    0
read     b     98    0
read     d     43    0
read     e     7a    0
read     f     bd    0
read     f     bd    1
read     0     3c    1
reset    0     00    0
read     0     3c    0
read     3     e2    0
read     0     3c    1
busy     9     6e    0
read     6     f4    0
read     9     6e    1
